// ==== hdl/lsu_defines.svh ====
// ======================================================================
// Width macros for the load/store unit. The package and the RTL that
// needs raw widths include this file.
// ======================================================================
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Bus and register data width
`define LSU_DATA_W 32

// Destination register index width
`define LSU_RF_IDX_W 5

// AHB size field width
`define LSU_HSIZE_W 3

// AHB transfer type field width
`define LSU_HTRANS_W 2

`endif

// ==== hdl/lsu_pkg.sv ====
// ======================================================================
// Shared types of the load/store unit: data vectors, size and transfer
// codes, and the mapping from access size to AHB hsize.
// ======================================================================
`include "lsu_defines.svh"

package lsu_pkg;

   typedef logic [`LSU_DATA_W-1:0]   word_t;
   typedef logic [`LSU_RF_IDX_W-1:0] rf_idx_t;
   typedef logic [1:0]               byte_off_t;
   typedef logic [`LSU_HSIZE_W-1:0]  hsize_t;

   typedef enum logic [`LSU_HTRANS_W-1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_NONSEQ = 2'b10
   } htrans_t;

   // Same coding as the RISC-V load funct3, bit 2 means unsigned
   typedef enum logic [2:0] {
      LSU_BYTE   = 3'b000,
      LSU_HALF   = 3'b001,
      LSU_WORD   = 3'b010,
      LSU_BYTE_U = 3'b100,
      LSU_HALF_U = 3'b101
   } lsu_size_t;

   // Low two bits already give byte, half or word
   function automatic hsize_t to_hsize(lsu_size_t size);
      return hsize_t'(size[1:0]);
   endfunction

endpackage

// ==== hdl/lsu_dphase_if.sv ====
// ======================================================================
// Data-phase context of one accepted transfer, handed from the
// address-phase stage to the load unit.
// ======================================================================
`timescale 1ns/100ps

interface lsu_dphase_if;
   import lsu_pkg::*;

   // A transfer is in its data phase
   logic      valid;
   // That transfer is a load
   logic      load;
   byte_off_t offset;
   lsu_size_t size;
   rf_idx_t   rd;

   // Written by the address-phase stage
   modport capture (output valid, load, offset, size, rd);

   // Read by the load unit
   modport extract (input valid, load, offset, size, rd);

endinterface

// ==== hdl/lsu_addr_phase.sv ====
// ======================================================================
// AHB-Lite address phase of the load/store unit. Drives the bus request,
// steers store data into byte lanes and captures data-phase context.
// ======================================================================
`timescale 1ns/100ps

module lsu_addr_phase (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   input  logic               req_write,
   input  lsu_pkg::lsu_size_t req_size,
   input  lsu_pkg::word_t     req_addr,
   input  lsu_pkg::word_t     req_wdata,
   input  lsu_pkg::rf_idx_t   req_rd,
   input  logic               hready,
   output lsu_pkg::word_t     haddr,
   output lsu_pkg::htrans_t   htrans,
   output logic               hwrite,
   output lsu_pkg::hsize_t    hsize,
   output lsu_pkg::word_t     hwdata,
   lsu_dphase_if.capture      dp
);
   import lsu_pkg::*;

   logic      accept;
   byte_off_t req_off;
   word_t     wdata_lanes;

   assign accept  = req_valid & hready;
   assign req_off = req_addr[1:0];

   // ====================================================================
   // Address phase
   // ====================================================================
   assign haddr  = req_addr;
   assign htrans = req_valid ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign hwrite = req_write;
   assign hsize  = to_hsize(req_size);

   // ====================================================================
   // Store data steering
   // ====================================================================
   // Unwritten lanes stay zero
   always_comb begin
      wdata_lanes = '0;
      case (req_size)
         LSU_BYTE, LSU_BYTE_U: begin
            wdata_lanes[8*req_off +: 8] = req_wdata[7:0];
         end
         LSU_HALF, LSU_HALF_U: begin
            wdata_lanes[16*req_off[1] +: 16] = req_wdata[15:0];
         end
         default: begin
            wdata_lanes = req_wdata;
         end
      endcase
   end

   // Held for the whole data phase of the store
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwdata <= '0;
      end else if (accept && req_write) begin
         hwdata <= wdata_lanes;
      end
   end

   // ====================================================================
   // Data-phase context
   // ====================================================================
   // A ready cycle without a request ends the context
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp.valid <= 1'b0;
         dp.load  <= 1'b0;
      end else if (hready) begin
         dp.valid <= req_valid;
         dp.load  <= req_valid & ~req_write;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dp.offset <= req_off;
         dp.size   <= req_size;
         dp.rd     <= req_rd;
      end
   end

   // Requester holds a stalled address phase
   a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (htrans == HTRANS_NONSEQ && !hready) |=> (htrans == HTRANS_NONSEQ && $stable(haddr)));

   a_half_align: assert property (@(posedge clk) disable iff (!rst_n)
      (req_valid && req_size inside {LSU_HALF, LSU_HALF_U}) |-> !req_addr[0]);

   a_word_align: assert property (@(posedge clk) disable iff (!rst_n)
      (req_valid && req_size == LSU_WORD) |-> (req_addr[1:0] == 2'b00));

endmodule

// ==== hdl/lsu_load_unit.sv ====
// ======================================================================
// Load data path of the load/store unit. Picks the addressed lane of
// hrdata, extends it and strobes the register write-back.
// ======================================================================
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_load_unit (
   input  logic             clk,
   input  logic             rst_n,
   lsu_dphase_if.extract    dp,
   input  logic             hready,
   input  lsu_pkg::word_t   hrdata,
   output logic             wb_valid,
   output lsu_pkg::rf_idx_t wb_rd,
   output lsu_pkg::word_t   wb_data
);
   import lsu_pkg::*;

   logic [7:0]  byte_lane;
   logic [15:0] half_lane;

   // Lane given by the offset captured in the address phase
   assign byte_lane = hrdata[8*dp.offset +: 8];
   assign half_lane = hrdata[16*dp.offset[1] +: 16];

   // ====================================================================
   // Extension
   // ====================================================================
   always_comb begin
      case (dp.size)
         LSU_BYTE: begin
            wb_data = {{(`LSU_DATA_W-8){byte_lane[7]}}, byte_lane};
         end
         LSU_BYTE_U: begin
            wb_data = {{(`LSU_DATA_W-8){1'b0}}, byte_lane};
         end
         LSU_HALF: begin
            wb_data = {{(`LSU_DATA_W-16){half_lane[15]}}, half_lane};
         end
         LSU_HALF_U: begin
            wb_data = {{(`LSU_DATA_W-16){1'b0}}, half_lane};
         end
         default: begin
            wb_data = hrdata;
         end
      endcase
   end

   // ====================================================================
   // Write-back
   // ====================================================================
   // Load data phase completes on the first ready cycle
   assign wb_valid = dp.valid & dp.load & hready;
   assign wb_rd    = dp.rd;

   // Write-back only for a load whose rd was captured at acceptance
   a_wb_load: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> (dp.valid && dp.load && !$isunknown(dp.rd)));

endmodule

// ==== hdl/lsu_top.sv ====
// ======================================================================
// Load/store unit top level with an AHB-Lite style master port.
// Requests come in on req_*, load results leave on wb_*.
// ======================================================================
`timescale 1ns/100ps

module lsu_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   input  logic               req_write,
   input  lsu_pkg::lsu_size_t req_size,
   input  lsu_pkg::word_t     req_addr,
   input  lsu_pkg::word_t     req_wdata,
   input  lsu_pkg::rf_idx_t   req_rd,
   input  logic               hready,
   input  lsu_pkg::word_t     hrdata,
   output lsu_pkg::word_t     haddr,
   output lsu_pkg::htrans_t   htrans,
   output logic               hwrite,
   output lsu_pkg::hsize_t    hsize,
   output lsu_pkg::word_t     hwdata,
   output logic               wb_valid,
   output lsu_pkg::rf_idx_t   wb_rd,
   output lsu_pkg::word_t     wb_data
);

   // Context of the transfer in its data phase
   lsu_dphase_if dp_if ();

   lsu_addr_phase u_addr_phase (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_write (req_write),
      .req_size  (req_size),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_rd    (req_rd),
      .hready    (hready),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hsize     (hsize),
      .hwdata    (hwdata),
      .dp        (dp_if.capture)
   );

   lsu_load_unit u_load_unit (
      .clk      (clk),
      .rst_n    (rst_n),
      .dp       (dp_if.extract),
      .hready   (hready),
      .hrdata   (hrdata),
      .wb_valid (wb_valid),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data)
   );

endmodule

// ==== testbench/tb_lsu.sv ====
// ======================================================================
// Testbench for the load/store unit. Runs a table of loads and stores
// against a 16-word AHB memory model with optional random wait states.
// ======================================================================
`timescale 1ns/100ps

module tb_lsu;
   import lsu_pkg::*;

   typedef struct {
      logic      write;
      lsu_size_t size;
      word_t     addr;
      word_t     data;
      rf_idx_t   rd;
      word_t     exp;
      int        grp;
   } row_t;

   logic clk, rst_n, req_valid, req_write, hready, hwrite, wb_valid;
   lsu_size_t req_size;
   word_t     req_addr, req_wdata, hrdata, haddr, hwdata, wb_data;
   rf_idx_t   req_rd, wb_rd;
   htrans_t   htrans;
   hsize_t    hsize;

   word_t       mem [16];
   word_t       shadow [16];
   row_t        rows [$];
   word_t       exp_data_q [$];
   rf_idx_t     exp_rd_q [$];
   int          exp_cyc_q [$];
   logic [31:0] rng_state = 32'd55;
   int          errors = 0;
   int          cyc = 0;
   logic        hold_ready = 1'b1;
   logic        dph_valid, dph_write, prev_stall;
   word_t       dph_addr, dph_hw_exp, prev_addr;
   lsu_size_t   dph_size;

   lsu_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic word_t lane_mask(lsu_size_t s, byte_off_t off);
      case (s)
         LSU_BYTE, LSU_BYTE_U: return 32'h0000_00FF << (8 * off);
         LSU_HALF, LSU_HALF_U: return 32'h0000_FFFF << (8 * off);
         default: return 32'hFFFF_FFFF;
      endcase
   endfunction

   // AHB hsize code of an access width
   function automatic hsize_t bus_size(lsu_size_t s);
      case (s)
         LSU_BYTE, LSU_BYTE_U: return 3'd0;
         LSU_HALF, LSU_HALF_U: return 3'd1;
         default:              return 3'd2;
      endcase
   endfunction

   // Replicate the low bytes across the bus, keep only the addressed lanes
   function automatic word_t steer(lsu_size_t s, byte_off_t off, word_t d);
      case (s)
         LSU_BYTE, LSU_BYTE_U: return {4{d[7:0]}} & lane_mask(s, off);
         LSU_HALF, LSU_HALF_U: return {2{d[15:0]}} & lane_mask(s, off);
         default: return d;
      endcase
   endfunction

   function automatic word_t extend(lsu_size_t s, byte_off_t off, word_t w);
      word_t sh;
      sh = w >> (8 * off);
      case (s)
         LSU_BYTE:   return {{24{sh[7]}}, sh[7:0]};
         LSU_BYTE_U: return {24'h0, sh[7:0]};
         LSU_HALF:   return {{16{sh[15]}}, sh[15:0]};
         LSU_HALF_U: return {16'h0, sh[15:0]};
         default:    return w;
      endcase
   endfunction

   // Expected load value comes from the shadow copy of earlier stores
   task automatic add_row(logic w, lsu_size_t s, word_t a, word_t d, rf_idx_t rd, int g);
      row_t r;
      word_t m;
      m = lane_mask(s, a[1:0]);
      r = '{write: w, size: s, addr: a, data: d, rd: rd, exp: '0, grp: g};
      if (w)
         shadow[a[5:2]] = (shadow[a[5:2]] & ~m) | (steer(s, a[1:0], d) & m);
      else
         r.exp = extend(s, a[1:0], shadow[a[5:2]]);
      rows.push_back(r);
   endtask

   // ====================================================================
   // Memory model
   // ====================================================================
   assign hrdata = mem[dph_addr[5:2]];

   always @(negedge clk) begin
      hready <= hold_ready ? 1'b1 : (xorshift() & 32'h3) != 0;
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dph_valid <= 1'b0;
         dph_write <= 1'b0;
         dph_addr  <= '0;
      end else if (hready) begin
         if (dph_valid && dph_write)
            mem[dph_addr[5:2]] <= (mem[dph_addr[5:2]] & ~lane_mask(dph_size, dph_addr[1:0]))
                                  | (hwdata & lane_mask(dph_size, dph_addr[1:0]));
         dph_valid  <= htrans == HTRANS_NONSEQ;
         dph_write  <= hwrite;
         dph_addr   <= haddr;
         dph_size   <= req_size;
         dph_hw_exp <= steer(req_size, req_addr[1:0], req_wdata);
      end
   end

   always @(posedge clk) cyc <= cyc + 1;

   // ====================================================================
   // Monitor, samples just before the rising edge
   // ====================================================================
   always @(negedge clk) begin
      #3;
      if (rst_n) begin
         if (prev_stall)
            assert (htrans == HTRANS_NONSEQ && haddr == prev_addr) else begin
               $display("FAILED haddr moved under wait state: 0x%h, was 0x%h", haddr, prev_addr);
               errors++;
            end
         prev_stall = (htrans == HTRANS_NONSEQ) && !hready;
         prev_addr  = haddr;
         if (htrans == HTRANS_NONSEQ)
            assert (hsize == bus_size(req_size)) else begin
               $display("FAILED hsize: got 0x%h, expected 0x%h", hsize, bus_size(req_size));
               errors++;
            end
         if (dph_valid && dph_write)
            assert (hwdata == dph_hw_exp) else begin
               $display("FAILED hwdata: got 0x%h, expected 0x%h", hwdata, dph_hw_exp);
               errors++;
            end
         if (wb_valid) begin
            assert (exp_data_q.size() > 0) else begin
               $display("Write-back appeared with no load pending");
               errors++;
            end
            if (exp_data_q.size() > 0) begin
               assert (wb_data == exp_data_q[0]) else begin
                  $display("FAILED wb_data: got 0x%h, expected 0x%h", wb_data, exp_data_q[0]);
                  errors++;
               end
               assert (wb_rd == exp_rd_q[0]) else begin
                  $display("FAILED wb_rd: got 0x%h, expected 0x%h", wb_rd, exp_rd_q[0]);
                  errors++;
               end
               assert (exp_cyc_q[0] < 0 || exp_cyc_q[0] == cyc) else begin
                  $display("Write-back came in cycle %0d, expected %0d", cyc, exp_cyc_q[0]);
                  errors++;
               end
               void'(exp_data_q.pop_front());
               void'(exp_rd_q.pop_front());
               void'(exp_cyc_q.pop_front());
            end
         end
      end
   end

   // ====================================================================
   // Stimulus
   // ====================================================================
   initial begin
      string names [6];
      lsu_size_t sizes [5];
      logic [31:0] r;
      lsu_size_t s;
      byte_off_t off;
      int g, err_start;
      names = '{"", "after reset", "word round trip", "store lane steering",
                "load extension", "random wait states"};
      sizes = '{LSU_BYTE, LSU_HALF, LSU_WORD, LSU_BYTE_U, LSU_HALF_U};
      rst_n = 1'b0;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_size = LSU_WORD;
      req_addr = '0;
      req_wdata = '0;
      req_rd = '0;
      hready = 1'b1;
      prev_stall = 1'b0;
      prev_addr = '0;
      for (int i = 0; i < 16; i++) begin
         mem[i] = 32'hC3A5_0000 ^ (i * 32'h0102_0409);
         shadow[i] = mem[i];
      end
      add_row(1, LSU_WORD, 32'h10, 32'hDEAD_BEEF, 5'd3, 2);
      add_row(0, LSU_WORD, 32'h10, 32'h0, 5'd7, 2);
      add_row(1, LSU_BYTE, 32'h20, 32'h0000_0011, 5'd0, 3);
      add_row(1, LSU_BYTE, 32'h21, 32'h0000_0022, 5'd0, 3);
      add_row(1, LSU_BYTE_U, 32'h22, 32'hFFFF_FF33, 5'd0, 3);
      add_row(1, LSU_BYTE, 32'h23, 32'h0000_0044, 5'd0, 3);
      add_row(0, LSU_WORD, 32'h20, 32'h0, 5'd9, 3);
      add_row(1, LSU_HALF, 32'h24, 32'hAAAA_5566, 5'd0, 3);
      add_row(1, LSU_HALF_U, 32'h26, 32'h0000_7788, 5'd0, 3);
      add_row(0, LSU_WORD, 32'h24, 32'h0, 5'd10, 3);
      add_row(1, LSU_WORD, 32'h28, 32'hF283_94A5, 5'd0, 4);
      for (int o = 0; o < 4; o++) begin
         add_row(0, LSU_BYTE, 32'h28 + o, 32'h0, rf_idx_t'(o + 1), 4);
         add_row(0, LSU_BYTE_U, 32'h28 + o, 32'h0, rf_idx_t'(o + 11), 4);
      end
      for (int o = 0; o < 4; o += 2) begin
         add_row(0, LSU_HALF, 32'h28 + o, 32'h0, rf_idx_t'(o + 20), 4);
         add_row(0, LSU_HALF_U, 32'h28 + o, 32'h0, rf_idx_t'(o + 21), 4);
      end
      for (int i = 0; i < 12; i++) begin
         r = xorshift();
         s = sizes[r[2:0] % 5];
         off = (s == LSU_WORD) ? 2'b00 : (s inside {LSU_HALF, LSU_HALF_U}) ? {r[6], 1'b0} : r[6:5];
         add_row(r[7], s, {26'h0, 2'b11, r[4:3], off}, xorshift(), rf_idx_t'(r[12:8]), 5);
      end

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      #3;
      assert (htrans == HTRANS_IDLE && !wb_valid && hwdata == '0) else begin
         $display("Bus not idle after reset: htrans 0x%h wb_valid %b", htrans, wb_valid);
         errors++;
      end
      $display("Test 1 %s finished, errors %0d", names[1], errors);

      for (int i = 0; i < rows.size(); i++) begin
         g = rows[i].grp;
         if (i == 0 || rows[i - 1].grp != g) begin
            err_start = errors;
            hold_ready = (g != 5);
         end
         @(negedge clk);
         req_valid = 1'b1;
         req_write = rows[i].write;
         req_size  = rows[i].size;
         req_addr  = rows[i].addr;
         req_wdata = rows[i].data;
         req_rd    = rows[i].rd;
         #4;
         while (!hready) begin
            @(negedge clk);
            #4;
         end
         if (!rows[i].write) begin
            exp_data_q.push_back(rows[i].exp);
            exp_rd_q.push_back(rows[i].rd);
            exp_cyc_q.push_back(hold_ready ? cyc + 1 : -1);
         end
         if (i == rows.size() - 1 || rows[i + 1].grp != g) begin
            @(negedge clk);
            req_valid = 1'b0;
            while (exp_data_q.size() > 0 || dph_valid)
               @(negedge clk);
            // Off the falling edge, so the next group's ready mode is settled
            #1;
            $display("Test %0d %s finished, errors %0d", g, names[g], errors - err_start);
         end
      end

      $display("Tests done: %0d rows applied, %0d errors", rows.size(), errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      #1;
      #(rows.size() * 10 * 10 + 200);
      $display("Timeout, the run did not reach its end in time");
      $display("** FAIL **");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_dphase_if.sv
hdl/lsu_addr_phase.sv
hdl/lsu_load_unit.sv
hdl/lsu_top.sv
testbench/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the load/store unit testbench with Verilator.
# Exit status is non-zero when the run reports a failure.

verilator --binary --timing --assert -f vlog.f --top-module tb_lsu \
   -Mdir obj_dir -o tb_lsu > build.log 2>&1 \
   && ./obj_dir/tb_lsu > sim.log 2>&1 \
   || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "\*\* FAIL \*\*" sim.log \
   && { echo "simulation failed, see sim.log"; exit 1; } \
   || { echo "simulation passed"; exit 0; }
